// File: dcache.f
+incdir+include
design/dcache_pkg.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/dcache.sv
verification/dcache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Mdir obj_dir
TOP       = dcache_tb
FLIST     = dcache.f
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# Exit status of the binary is the pass or fail of the run
run: compile
	./$(BIN)

clean:
	rm -rf obj_dir

// File: verification/dcache_cases.txt
# op addr data miss wb, data is write data for W and the expected word for R
# miss is 1 when the access must go to the bus, wb counts write transfers

# Cold read of set 2 fetches both words
R 00000010 c0de0010 1 0
R 00000014 c0de0014 0 0

# Write hit then read back, the other word keeps its fetched value
W 00000014 11112222 0 0
R 00000014 11112222 0 0
R 00000010 c0de0010 0 0

# Fill the second way of set 2 and dirty it
R 00000050 c0de0050 1 0
W 00000054 33334444 0 0

# Set full, dirty tag 0 goes out before the fill
R 00000090 c0de0090 1 2
R 00000014 11112222 1 2

# Set 5 LRU, touch A then B then A, then C must evict B
W 000000e8 aaaa0001 1 0
W 0000012c bbbb0001 1 0
R 000000e8 aaaa0001 0 0
R 00000168 c0de0168 1 2
R 000000e8 aaaa0001 0 0
R 0000012c bbbb0001 1 0
W 000000ec aaaa0002 0 0

# More dirty blocks in sets 0 and 7
W 00000000 0000beef 1 0
W 000003f8 77770000 1 0

# Flush, three dirty blocks left
H 00000000 00000000 0 6

// File: verification/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;

	import dcache_pkg::*;

	localparam int MEM_WORDS  = 1024;
	localparam int WORD_BYTES = 1 << `DCACHE_BYTE_W;
	localparam int MEM_BYTES  = MEM_WORDS * WORD_BYTES;
	localparam int BLK_LSB    = `DCACHE_BYTE_W + 1;
	localparam int TIMEOUT    = 1000;
	localparam addr_t BLK_MASK = ~addr_t'((1 << BLK_LSB) - 1);

	// DUT ports
	logic  CLK;
	logic  nRST;
	logic  ren;
	logic  wen;
	addr_t addr;
	word_t wdata;
	logic  halt;
	word_t wb_dat_r;
	logic  wb_ack;
	word_t rdata;
	logic  hit;
	logic  flushed;
	logic  wb_cyc;
	logic  wb_stb;
	logic  wb_we;
	addr_t wb_adr;
	word_t wb_dat_w;

	// Wishbone slave memory and its bookkeeping
	word_t      mem [MEM_WORDS];
	word_t      exp_mem [MEM_WORDS];
	logic       busy;
	logic [1:0] wait_left;
	logic [31:0] rng;
	addr_t      held_adr;
	int         rd_cnt;
	int         wr_cnt;

	// Every completed transfer in bus order
	logic  log_we [$];
	addr_t log_adr [$];

	// Cases file fields
	int          fd;
	string       line;
	logic [7:0]  op;
	addr_t       case_adr;
	word_t       case_dat;
	int          case_miss;
	int          case_wb;
	int          fields;

	dcache i_dut (
		.CLK      (CLK),
		.nRST     (nRST),
		.ren      (ren),
		.wen      (wen),
		.addr     (addr),
		.wdata    (wdata),
		.halt     (halt),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.rdata    (rdata),
		.hit      (hit),
		.flushed  (flushed),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	////////////////////////////////////////
	// Reporting and compares
	////////////////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t got);
		if (got !== exp) begin
			abort_run($sformatf("error %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t got);
		if (got !== exp) begin
			abort_run($sformatf("error %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			abort_run($sformatf("error %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		if (got != exp) begin
			abort_run($sformatf("error %s expected %h got %h", name, exp, got));
		end
	endtask

	// Xorshift step with shifts of 13, 17 and 5
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	////////////////////////////////////////
	// Wishbone slave model
	////////////////////////////////////////

	initial begin
		wb_ack    = 1'b0;
		wb_dat_r  = '0;
		busy      = 1'b0;
		wait_left = '0;
		held_adr  = '0;
		rd_cnt    = 0;
		wr_cnt    = 0;
		rng       = 32'hee5d;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = word_t'(i * WORD_BYTES) ^ 32'hc0de0000;
		end
		forever begin
			@(posedge CLK);
			#1;
			if (wb_ack) begin
				// Master took the ack on this edge
				wb_ack = 1'b0;
				busy   = 1'b0;
			end else if (wb_cyc) begin
				if (!busy) begin
					// New transfer picks 0 to 3 wait cycles
					busy      = 1'b1;
					rng       = xorshift(rng);
					wait_left = rng[1:0];
					held_adr  = wb_adr;
				end
				check_flag("wb_stb", 1'b1, wb_stb);
				check_addr("wb_adr", held_adr, wb_adr);
				if (wait_left != 0) begin
					wait_left = wait_left - 1'b1;
				end else begin
					if (wb_adr >= addr_t'(MEM_BYTES)) begin
						abort_run("bus address outside the memory model");
					end
					if (wb_we) begin
						mem[wb_adr[`DCACHE_BYTE_W +: 10]] = wb_dat_w;
						wr_cnt++;
					end else begin
						wb_dat_r = mem[wb_adr[`DCACHE_BYTE_W +: 10]];
						rd_cnt++;
					end
					log_we.push_back(wb_we);
					log_adr.push_back(wb_adr);
					wb_ack = 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// Sequences
	////////////////////////////////////////

	// Write-backs come first as word 0 and word 1 pairs and the fill reads follow
	task automatic check_order(input int first, input addr_t req, input logic same_set,
		input int nwb, input int nrd);
		addr_t base;
		addr_t wa;
		check_count("bus transfers", nwb + nrd, log_adr.size() - first);
		for (int k = first; k < first + nwb; k += 2) begin
			base = log_adr[k] & BLK_MASK;
			// Victim lives in the request's set
			if (same_set) begin
				base[BLK_LSB +: `DCACHE_IDX_W] = req[BLK_LSB +: `DCACHE_IDX_W];
			end
			check_flag("wb_we", 1'b1, log_we[k]);
			check_addr("wb_adr", base, log_adr[k]);
			check_flag("wb_we", 1'b1, log_we[k+1]);
			check_addr("wb_adr", base + addr_t'(WORD_BYTES), log_adr[k+1]);
			// Written words carry the latest stored values of their own addresses
			for (int j = 0; j < 2; j++) begin
				wa = log_adr[k+j];
				check_word($sformatf("mem[%0h]", wa), exp_mem[wa[`DCACHE_BYTE_W +: 10]],
					mem[wa[`DCACHE_BYTE_W +: 10]]);
			end
		end
		for (int k = first + nwb; k < first + nwb + nrd; k++) begin
			base = (req & BLK_MASK) + addr_t'((k - first - nwb) * WORD_BYTES);
			check_flag("wb_we", 1'b0, log_we[k]);
			check_addr("wb_adr", base, log_adr[k]);
		end
	endtask

	// One read or write held until hit
	task automatic run_access(input logic is_wr, input addr_t a, input word_t d,
		input logic miss, input int nwb);
		int cycles;
		int rd0;
		int wr0;
		int first;
		cycles = 0;
		rd0    = rd_cnt;
		wr0    = wr_cnt;
		first  = log_adr.size();
		@(posedge CLK);
		#1;
		ren   = !is_wr;
		wen   = is_wr;
		addr  = a;
		wdata = is_wr ? d : '0;
		@(negedge CLK);
		while (!hit) begin
			cycles++;
			if (cycles > TIMEOUT) begin
				abort_run($sformatf("timeout waiting for hit on address %h", a));
			end
			@(negedge CLK);
		end
		check_flag("miss", miss, cycles != 0);
		if (!is_wr) begin
			check_word("rdata", d, rdata);
		end
		// Request completes on this edge
		@(posedge CLK);
		#1;
		ren = 1'b0;
		wen = 1'b0;
		check_count("bus reads", miss ? 2 : 0, rd_cnt - rd0);
		check_count("bus writes", nwb, wr_cnt - wr0);
		check_order(first, a, 1'b1, nwb, miss ? 2 : 0);
		if (is_wr) begin
			exp_mem[a[`DCACHE_BYTE_W +: 10]] = d;
		end
	endtask

	// Halt then wait for flushed and compare the whole memory
	task automatic run_flush(input int nwb);
		int cycles;
		int rd0;
		int wr0;
		int first;
		cycles = 0;
		rd0    = rd_cnt;
		wr0    = wr_cnt;
		first  = log_adr.size();
		@(posedge CLK);
		#1;
		halt = 1'b1;
		@(negedge CLK);
		while (!flushed) begin
			cycles++;
			if (cycles > TIMEOUT) begin
				abort_run("timeout waiting for flushed after halt");
			end
			@(negedge CLK);
		end
		check_count("bus reads", 0, rd_cnt - rd0);
		check_count("bus writes", nwb, wr_cnt - wr0);
		check_order(first, '0, 1'b0, nwb, 0);
		// Flushed stays high and the bus stays quiet
		repeat (4) begin
			@(negedge CLK);
			check_flag("flushed", 1'b1, flushed);
			check_flag("wb_cyc", 1'b0, wb_cyc);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			check_word($sformatf("mem[%0h]", i * WORD_BYTES), exp_mem[i], mem[i]);
		end
	endtask

	////////////////////////////////////////
	// Main
	////////////////////////////////////////

	initial begin
		nRST  = 1'b0;
		ren   = 1'b0;
		wen   = 1'b0;
		addr  = '0;
		wdata = '0;
		halt  = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			exp_mem[i] = word_t'(i * WORD_BYTES) ^ 32'hc0de0000;
		end
		repeat (5) @(posedge CLK);
		#1;
		nRST = 1'b1;
		@(negedge CLK);
		check_flag("hit", 1'b0, hit);
		check_flag("flushed", 1'b0, flushed);
		check_flag("wb_cyc", 1'b0, wb_cyc);
		check_flag("wb_stb", 1'b0, wb_stb);
		check_flag("wb_we", 1'b0, wb_we);

		fd = $fopen("verification/dcache_cases.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open the cases file");
		end
		while ($fgets(line, fd) != 0) begin
			// Blank and comment lines
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			fields = $sscanf(line, "%c %h %h %d %d", op, case_adr, case_dat,
				case_miss, case_wb);
			if (fields != 5) begin
				abort_run("malformed line in the cases file");
			end
			case (op)
				"R": run_access(1'b0, case_adr, case_dat, case_miss != 0, case_wb);
				"W": run_access(1'b1, case_adr, case_dat, case_miss != 0, case_wb);
				"H": run_flush(case_wb);
				default: abort_run("unknown operation in the cases file");
			endcase
		end
		$fclose(fd);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: design/dcache.sv
`timescale 1ns/1ps

module dcache (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              ren,
	input  logic              wen,
	input  dcache_pkg::addr_t addr,
	input  dcache_pkg::word_t wdata,
	input  logic              halt,
	input  dcache_pkg::word_t wb_dat_r,
	input  logic              wb_ack,
	output dcache_pkg::word_t rdata,
	output logic              hit,
	output logic              flushed,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output dcache_pkg::addr_t wb_adr,
	output dcache_pkg::word_t wb_dat_w
);

	import dcache_pkg::*;

	// Lookup results
	logic  match;
	logic  victim_way;
	logic  victim_dirty;
	tag_t  victim_tag;
	logic  any_dirty;
	slot_t dirty_slot;
	tag_t  wb_tag;
	word_t wb_word;

	// Array controls
	logic  access_en;
	logic  fill_en;
	logic  fill_word;
	word_t fill_data;
	slot_t wb_slot;
	logic  word_sel;
	logic  clean_en;

	// Storage and lookup
	// Hit way only steers writes inside the array
	dcache_array i_array (
		.CLK          (CLK),
		.nRST         (nRST),
		.addr         (addr),
		.wdata        (wdata),
		.wen          (wen),
		.access_en    (access_en),
		.fill_en      (fill_en),
		.fill_word    (fill_word),
		.fill_data    (fill_data),
		.wb_slot      (wb_slot),
		.word_sel     (word_sel),
		.clean_en     (clean_en),
		.match        (match),
		.match_way    (),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.any_dirty    (any_dirty),
		.dirty_slot   (dirty_slot),
		.rdata        (rdata),
		.wb_tag       (wb_tag),
		.wb_word      (wb_word)
	);

	// Miss and flush sequencing, Wishbone master
	dcache_ctrl i_ctrl (
		.CLK          (CLK),
		.nRST         (nRST),
		.ren          (ren),
		.wen          (wen),
		.addr         (addr),
		.halt         (halt),
		.match        (match),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.any_dirty    (any_dirty),
		.dirty_slot   (dirty_slot),
		.wb_tag       (wb_tag),
		.wb_word      (wb_word),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.hit          (hit),
		.flushed      (flushed),
		.access_en    (access_en),
		.fill_en      (fill_en),
		.fill_word    (fill_word),
		.fill_data    (fill_data),
		.wb_slot      (wb_slot),
		.word_sel     (word_sel),
		.clean_en     (clean_en),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w)
	);

endmodule

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              ren,
	input  logic              wen,
	input  dcache_pkg::addr_t addr,
	input  logic              halt,
	input  logic              match,
	input  logic              victim_way,
	input  logic              victim_dirty,
	input  dcache_pkg::tag_t  victim_tag,
	input  logic              any_dirty,
	input  dcache_pkg::slot_t dirty_slot,
	input  dcache_pkg::tag_t  wb_tag,
	input  dcache_pkg::word_t wb_word,
	input  dcache_pkg::word_t wb_dat_r,
	input  logic              wb_ack,
	output logic              hit,
	output logic              flushed,
	output logic              access_en,
	output logic              fill_en,
	output logic              fill_word,
	output dcache_pkg::word_t fill_data,
	output dcache_pkg::slot_t wb_slot,
	output logic              word_sel,
	output logic              clean_en,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output dcache_pkg::addr_t wb_adr,
	output dcache_pkg::word_t wb_dat_w
);

	import dcache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	// Request fields
	tag_t req_tag;
	idx_t req_idx;
	logic req;

	// Tag and index of the block on the bus
	tag_t adr_tag;
	idx_t adr_idx;

	assign req_tag = addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
	assign req_idx = addr[`DCACHE_BYTE_W+`DCACHE_OFF_W +: `DCACHE_IDX_W];
	assign req     = ren | wen;

	////////////////////////////////////////
	// Core side
	////////////////////////////////////////

	// Hit only from IDLE, same cycle as the request
	assign hit       = (state == IDLE) && req && match;
	assign access_en = hit;

	// Sticky until reset, FLUSHED has no exit
	assign flushed = (state == FLUSHED);

	// Read data goes straight into the array
	assign fill_data = wb_dat_r;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				// Halt wins over a pending miss
				if (halt) begin
					next_state = DCHK;
				end else if (req && !match) begin
					next_state = victim_dirty ? WB1 : FD1;
				end
			end
			// Every bus state waits for its ack
			WB1:  if (wb_ack) next_state = WB2;
			WB2:  if (wb_ack) next_state = FD1;
			FD1:  if (wb_ack) next_state = FD2;
			// Back to IDLE, the held request then hits
			FD2:  if (wb_ack) next_state = IDLE;
			// Look for another dirty frame
			DCHK: next_state = any_dirty ? WBD1 : FLUSHED;
			WBD1: if (wb_ack) next_state = WBD2;
			WBD2: if (wb_ack) next_state = DCHK;
			FLUSHED: next_state = FLUSHED;
			default: next_state = IDLE;
		endcase
	end

	////////////////////////////////////////
	// Bus and array controls
	////////////////////////////////////////

	always_comb begin
		// Defaults point at the request and its victim
		wb_cyc   = 1'b0;
		wb_we    = 1'b0;
		word_sel = 1'b0;
		wb_slot  = {req_idx, victim_way};
		adr_tag  = req_tag;
		adr_idx  = req_idx;
		fill_en  = 1'b0;
		clean_en = 1'b0;
		case (state)
			WB1, WB2: begin
				// Victim goes back to its own address
				wb_cyc   = 1'b1;
				wb_we    = 1'b1;
				word_sel = (state == WB2);
				adr_tag  = victim_tag;
			end
			FD1, FD2: begin
				// Array writes on the ack edge only
				wb_cyc   = 1'b1;
				word_sel = (state == FD2);
				fill_en  = wb_ack;
			end
			WBD1, WBD2: begin
				wb_cyc   = 1'b1;
				wb_we    = 1'b1;
				word_sel = (state == WBD2);
				wb_slot  = dirty_slot;
				adr_tag  = wb_tag;
				adr_idx  = dirty_slot[`DCACHE_IDX_W:1];
				// Frame is clean once its second word lands
				clean_en = (state == WBD2) && wb_ack;
			end
			default: begin
				wb_cyc = 1'b0;
			end
		endcase
	end

	// Fill word follows the bus word
	assign fill_word = word_sel;

	// Classic single transfers, stb tracks cyc
	assign wb_stb   = wb_cyc;
	assign wb_adr   = {adr_tag, adr_idx, word_sel, {`DCACHE_BYTE_W{1'b0}}};
	assign wb_dat_w = wb_word;

	// State register
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

endmodule

// File: design/dcache_array.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_array (
	input  logic              CLK,
	input  logic              nRST,
	input  dcache_pkg::addr_t addr,
	input  dcache_pkg::word_t wdata,
	input  logic              wen,
	input  logic              access_en,
	input  logic              fill_en,
	input  logic              fill_word,
	input  dcache_pkg::word_t fill_data,
	input  dcache_pkg::slot_t wb_slot,
	input  logic              word_sel,
	input  logic              clean_en,
	output logic              match,
	output logic              match_way,
	output logic              victim_way,
	output logic              victim_dirty,
	output dcache_pkg::tag_t  victim_tag,
	output logic              any_dirty,
	output dcache_pkg::slot_t dirty_slot,
	output dcache_pkg::word_t rdata,
	output dcache_pkg::tag_t  wb_tag,
	output dcache_pkg::word_t wb_word
);

	import dcache_pkg::*;

	// Per way, per set storage
	tag_t  tags  [2][`DCACHE_SETS];
	logic  valid [2][`DCACHE_SETS];
	logic  dirty [2][`DCACHE_SETS];
	word_t data  [2][`DCACHE_SETS][`DCACHE_WORDS];

	// One bit per set, names the way to replace next
	logic [`DCACHE_SETS-1:0] lru;

	// Request address fields
	tag_t req_tag;
	idx_t req_idx;
	logic req_off;

	// Tag compare result per way
	logic [1:0] way_hit;

	// Frame picked by the controller for write-back
	idx_t wb_idx;
	logic wb_way;

	////////////////////////////////////////
	// Lookup
	////////////////////////////////////////

	assign req_tag = addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
	assign req_idx = addr[`DCACHE_BYTE_W+`DCACHE_OFF_W +: `DCACHE_IDX_W];
	assign req_off = addr[`DCACHE_BYTE_W];

	// Both ways compared in parallel
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid[w][req_idx] && (tags[w][req_idx] == req_tag);
		end
	end

	assign match = |way_hit;

	// A tag lives in one way at most, so way 1 alone decides
	assign match_way = way_hit[1];

	// Read word picked by block offset
	assign rdata = data[match_way][req_idx][req_off];

	// Replacement candidate for the request's set
	assign victim_way   = lru[req_idx];
	assign victim_dirty = dirty[victim_way][req_idx];
	assign victim_tag   = tags[victim_way][req_idx];

	////////////////////////////////////////
	// Write-back readout
	////////////////////////////////////////

	assign wb_idx = wb_slot[`DCACHE_IDX_W:1];
	assign wb_way = wb_slot[0];

	assign wb_tag  = tags[wb_way][wb_idx];
	assign wb_word = data[wb_way][wb_idx][word_sel];

	// Flush scan
	// Walks from the top frame down so the lowest dirty frame wins
	always_comb begin
		any_dirty  = 1'b0;
		dirty_slot = '0;
		for (int s = 2*`DCACHE_SETS-1; s >= 0; s--) begin
			if (dirty[s % 2][s / 2]) begin
				any_dirty  = 1'b1;
				dirty_slot = slot_t'(s);
			end
		end
	end

	////////////////////////////////////////
	// Updates
	////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
			for (int w = 0; w < 2; w++) begin
				for (int s = 0; s < `DCACHE_SETS; s++) begin
					tags[w][s]  <= '0;
					valid[w][s] <= 1'b0;
					dirty[w][s] <= 1'b0;
					for (int k = 0; k < `DCACHE_WORDS; k++) begin
						data[w][s][k] <= '0;
					end
				end
			end
		end else if (access_en) begin
			// Hit, the other way becomes the replacement choice
			lru[req_idx] <= ~match_way;
			if (wen) begin
				data[match_way][req_idx][req_off] <= wdata;
				dirty[match_way][req_idx]         <= 1'b1;
			end
		end else if (fill_en) begin
			// Fill goes into the victim way of the request's set
			data[victim_way][req_idx][fill_word] <= fill_data;
			if (!fill_word) begin
				// First word, frame is not usable yet
				valid[victim_way][req_idx] <= 1'b0;
				dirty[victim_way][req_idx] <= 1'b0;
			end else begin
				// Second word completes the block
				tags[victim_way][req_idx]  <= req_tag;
				valid[victim_way][req_idx] <= 1'b1;
			end
		end else if (clean_en) begin
			// Flushed frame now matches memory
			dirty[wb_way][wb_idx] <= 1'b0;
		end
	end

endmodule

// File: design/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

	// Byte address from the core
	typedef logic [`DCACHE_ADDR_W-1:0] addr_t;

	// One data word, cache and bus side
	typedef logic [`DCACHE_DATA_W-1:0] word_t;

	// Block tag kept per way
	typedef logic [`DCACHE_TAG_W-1:0] tag_t;

	// Set index
	typedef logic [`DCACHE_IDX_W-1:0] idx_t;

	// Block frame, set index on top and way in the low bit
	typedef logic [`DCACHE_IDX_W:0] slot_t;

	// Miss and flush sequencer
	// WB is victim write-back, FD is fill, WBD is flush write-back
	typedef enum logic [3:0] {
		IDLE    = 4'd0,
		WB1     = 4'd1,
		WB2     = 4'd2,
		FD1     = 4'd3,
		FD2     = 4'd4,
		DCHK    = 4'd5,
		WBD1    = 4'd6,
		WBD2    = 4'd7,
		FLUSHED = 4'd8
	} ctrl_state_t;

endpackage

// File: include/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Byte address and data word widths
`define DCACHE_ADDR_W 32
`define DCACHE_DATA_W 32

// Address split, high to low
// Tag, set index, word in block, byte in word
`define DCACHE_TAG_W  26
`define DCACHE_IDX_W  3
`define DCACHE_OFF_W  1
`define DCACHE_BYTE_W 2

// Cache geometry
// Two ways per set, two words per block
`define DCACHE_SETS  8
`define DCACHE_WORDS 2

`endif
